/* Makefile */
# Verilator build and run for the back-end slice testbench
VERILATOR ?= verilator
TOP ?= tb_backend
SEED ?= 1
LOG ?= sim.log
BUILD_DIR ?= obj_dir

VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Pass or fail comes from the log, not from the simulator exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f all.f
	./$(BUILD_DIR)/V$(TOP) +verilator+seed+$(SEED) 2>&1 | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || \
		(echo "Pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* all.f */
+incdir+dv
source/be_pkg.sv
source/alu_pipe.sv
source/wb_arbiter.sv
source/dispatch_queue.sv
source/backend_top.sv
dv/tb_backend.sv

/* dv/tb_model.svh */
// ====================
// Reference model, included inside the testbench module body
// Needs be_pkg imported and NUM_TAGS, ORDER_SLACK, err_cnt declared first
// ====================
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// Per-tag state of the live instance of each tag
bit outst [NUM_TAGS];
int tag_seq [NUM_TAGS];
logic [DATA_W-1:0] exp_res [NUM_TAGS];
// Producer sequence numbers, -1 when ready at entry
int dep_seq [NUM_TAGS][2];
// One bit per accepted micro-op in program order, set at writeback
bit done_seq [$];
int n_outst;
int wb_cnt;

// Result from the operation table
function automatic logic [DATA_W-1:0] alu_expect(input alu_op_e op,
	input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
	case (op)
		ALU_ADD: return a + b;
		ALU_SUB: return a - b;
		ALU_XOR: return a ^ b;
		default: return a & b;
	endcase
endfunction

// Sources must be looked up before pdest goes live
function automatic void record_accept(input uop_t u);
	int seq;
	seq = done_seq.size();
	dep_seq[u.pdest][0] = u.src0_ready ? -1 : tag_seq[u.src0];
	dep_seq[u.pdest][1] = u.src1_ready ? -1 : tag_seq[u.src1];
	tag_seq[u.pdest] = seq;
	exp_res[u.pdest] = alu_expect(u.op, u.opa, u.opb);
	outst[u.pdest] = 1'b1;
	n_outst++;
	done_seq.push_back(1'b0);
endfunction

function automatic void check_writeback(input wb_t w);
	int seq;
	int older;
	if (!outst[w.tag]) begin
		$display("** Error @ %0t ns: writeback of tag %0d, which is not outstanding",
			$time, w.tag);
		err_cnt++;
		return;
	end
	seq = tag_seq[w.tag];
	if (w.result !== exp_res[w.tag]) begin
		$display("** Error @ %0t ns: tag %0d result %h, expected %h",
			$time, w.tag, w.result, exp_res[w.tag]);
		err_cnt++;
	end
	// Producers of pending sources go first
	for (int k = 0; k < 2; k++) begin
		if (dep_seq[w.tag][k] >= 0 && !done_seq[dep_seq[w.tag][k]]) begin
			$display("** Error @ %0t ns: tag %0d wrote back before producer seq %0d",
				$time, w.tag, dep_seq[w.tag][k]);
			err_cnt++;
		end
	end
	// Older live ops can only sit in the other pipe
	older = 0;
	for (int s = 0; s < seq; s++) begin
		if (!done_seq[s]) begin
			older++;
		end
	end
	if (older > ORDER_SLACK) begin
		$display("** Error @ %0t ns: tag %0d passed %0d older micro-ops",
			$time, w.tag, older);
		err_cnt++;
	end
	done_seq[seq] = 1'b1;
	outst[w.tag] = 1'b0;
	n_outst--;
	wb_cnt++;
endfunction

`endif

/* dv/tb_backend.sv */
// ====================
// Random micro-op stream against backend_top, checked by an in-module model
// Fixed seed, 400 micro-ops, at most 16 tags live, a tag is reused only once free
// ====================
`timescale 1ns/1ns

module tb_backend;

	import be_pkg::*;

	localparam int NUM_TAGS = 1 << PTAG_W;
	localparam int MAX_OUTSTANDING = 16;
	localparam int TOTAL_UOPS = 400;
	localparam int TIMEOUT_CYCLES = 20000;
	// Two stages of the other pipe
	localparam int ORDER_SLACK = 2;
	// Stage one plus hold register in every pipe
	localparam int PIPE_SLOTS = 2 * DISPATCH_WIDTH;
	localparam logic [31:0] SEED = 32'h6969;

	logic clk;
	logic rst_n;
	logic [DECODE_WIDTH-1:0] wr_valid_i;
	uop_t [DECODE_WIDTH-1:0] wr_uop_i;
	logic wr_ready_o;
	logic wb_valid_o;
	wb_t wb_o;

	int err_cnt;
	int sent_cnt;
	logic [PTAG_W-1:0] tag_ctr;

	`include "tb_model.svh"

	backend_top i_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_valid_i (wr_valid_i),
		.wr_uop_i   (wr_uop_i),
		.wr_ready_o (wr_ready_o),
		.wb_valid_o (wb_valid_o),
		.wb_o       (wb_o)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	// ====================
	// Stimulus
	// ====================

	// Half ready at entry, rest wait on a live tag
	function automatic void pick_source(output logic [PTAG_W-1:0] tag, output logic rdy);
		int start;
		int t;
		tag = PTAG_W'($urandom);
		rdy = 1'b1;
		if ($urandom_range(0, 1) == 0) begin
			return;
		end
		start = $urandom_range(0, NUM_TAGS - 1);
		for (int i = 0; i < NUM_TAGS; i++) begin
			t = (start + i) % NUM_TAGS;
			if (outst[t]) begin
				tag = PTAG_W'(t);
				rdy = 1'b0;
				return;
			end
		end
	endfunction

	function automatic uop_t make_uop(input logic [PTAG_W-1:0] dest);
		uop_t u;
		u.pdest = dest;
		pick_source(u.src0, u.src0_ready);
		pick_source(u.src1, u.src1_ready);
		u.op = alu_op_e'($urandom_range(0, 3));
		u.opa = DATA_W'($urandom);
		u.opb = DATA_W'($urandom);
		return u;
	endfunction

	// Ready only reflects the counter, so acceptance is known here
	task automatic drive_lanes();
		uop_t u;
		wr_valid_i = '0;
		wr_uop_i = '0;
		if (wr_ready_o !== 1'b1) begin
			return;
		end
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (sent_cnt < TOTAL_UOPS && n_outst < MAX_OUTSTANDING && !outst[tag_ctr]
				&& $urandom_range(0, 3) != 0) begin
				u = make_uop(tag_ctr);
				record_accept(u);
				wr_uop_i[i] = u;
				wr_valid_i[i] = 1'b1;
				tag_ctr = tag_ctr + 1'b1;
				sent_cnt++;
			end
		end
	endtask

	// In-flight count bounds the queue count from above
	// Queue holds at least in-flight minus the pipe slots
	task automatic check_ready();
		if (n_outst <= QUEUE_DEPTH - DECODE_WIDTH && wr_ready_o !== 1'b1) begin
			$display("** Error @ %0t ns: wr_ready_o low with %0d in flight", $time, n_outst);
			err_cnt++;
		end
		if (n_outst > QUEUE_DEPTH - DECODE_WIDTH + PIPE_SLOTS && wr_ready_o !== 1'b0) begin
			$display("** Error @ %0t ns: wr_ready_o high with %0d in flight", $time, n_outst);
			err_cnt++;
		end
	endtask

	// Writeback monitor
	always @(posedge clk) begin
		if (rst_n && $isunknown(wb_valid_o)) begin
			$display("** Error @ %0t ns: wb_valid_o unknown", $time);
			err_cnt++;
		end else if (rst_n && wb_valid_o) begin
			check_writeback(wb_o);
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial begin
		int cycles;
		void'($urandom(SEED));
		rst_n = 1'b0;
		wr_valid_i = '0;
		wr_uop_i = '0;
		err_cnt = 0;
		sent_cnt = 0;
		tag_ctr = '0;
		n_outst = 0;
		wb_cnt = 0;
		repeat (5) @(negedge clk);
		if (wb_valid_o !== 1'b0 || wr_ready_o !== 1'b1) begin
			$display("** Error @ %0t ns: reset state wb_valid_o=%b wr_ready_o=%b",
				$time, wb_valid_o, wr_ready_o);
			err_cnt++;
		end
		rst_n = 1'b1;
		cycles = 0;
		while (wb_cnt < TOTAL_UOPS && cycles < TIMEOUT_CYCLES) begin
			@(negedge clk);
			check_ready();
			drive_lanes();
			cycles++;
		end
		if (wb_cnt < TOTAL_UOPS) begin
			$display("Timeout: only %0d of %0d micro-ops wrote back after %0d cycles",
				wb_cnt, TOTAL_UOPS, cycles);
			err_cnt++;
		end
		// Idle drain catches late or repeated writebacks
		wr_valid_i = '0;
		repeat (20) @(negedge clk);
		if (n_outst != 0) begin
			$display("%0d accepted micro-ops never wrote back", n_outst);
			err_cnt++;
		end
		$display("Summary: %0d sent, %0d written back, %0d errors", sent_cnt, wb_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule : tb_backend

/* source/alu_pipe.sv */
// ====================
// Two-stage ALU, result held until the writeback grant
// Accepts only while the hold register frees at the next edge
// ====================
`timescale 1ns/1ns

module alu_pipe (
	input  logic clk,
	input  logic rst_n,
	input  logic in_valid_i,
	input  be_pkg::uop_t in_uop_i,
	output logic in_ready_o,
	output logic req_o,
	output be_pkg::wb_t wb_o,
	input  logic grant_i
);

	import be_pkg::*;

	// Stage one operands
	logic s1_valid_q;
	logic [PTAG_W-1:0] s1_tag_q;
	alu_op_e s1_op_q;
	logic [DATA_W-1:0] s1_opa_q, s1_opb_q;

	// Hold register
	logic hold_valid_q;
	wb_t hold_q;
	logic hold_free;
	logic [DATA_W-1:0] alu_res;

	// Hold empties this edge if empty now or granted now
	assign hold_free = !hold_valid_q || grant_i;
	assign in_ready_o = hold_free;

	always_comb begin
		case (s1_op_q)
			ALU_ADD: alu_res = s1_opa_q + s1_opb_q;
			ALU_SUB: alu_res = s1_opa_q - s1_opb_q;
			ALU_XOR: alu_res = s1_opa_q ^ s1_opb_q;
			default: alu_res = s1_opa_q & s1_opb_q;
		endcase
	end

	// Both stages advance together when the hold frees
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			s1_valid_q <= 1'b0;
			hold_valid_q <= 1'b0;
		end else if (hold_free) begin
			s1_valid_q <= in_valid_i;
			hold_valid_q <= s1_valid_q;
		end
	end

	always_ff @(posedge clk) begin
		if (hold_free && in_valid_i) begin
			s1_tag_q <= in_uop_i.pdest;
			s1_op_q <= in_uop_i.op;
			s1_opa_q <= in_uop_i.opa;
			s1_opb_q <= in_uop_i.opb;
		end
		if (hold_free && s1_valid_q) begin
			hold_q.tag <= s1_tag_q;
			hold_q.result <= alu_res;
		end
	end

	assign req_o = hold_valid_q;
	assign wb_o = hold_q;

	// Arbiter only grants a live request
	a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
		grant_i |-> req_o)
		else $error("alu pipe granted without request");

endmodule : alu_pipe

/* source/backend_top.sv */
// ====================
// Back-end slice top, queue feeding two ALU pipes
// Single writeback bus doubles as the queue wakeup
// ====================
`timescale 1ns/1ns

module backend_top (
	input  logic clk,
	input  logic rst_n,
	input  logic [be_pkg::DECODE_WIDTH-1:0] wr_valid_i,
	input  be_pkg::uop_t [be_pkg::DECODE_WIDTH-1:0] wr_uop_i,
	output logic wr_ready_o,
	output logic wb_valid_o,
	output be_pkg::wb_t wb_o
);

	import be_pkg::*;

	// Dispatch lanes
	logic [DISPATCH_WIDTH-1:0] rd_valid;
	uop_t [DISPATCH_WIDTH-1:0] rd_uop;
	logic [DISPATCH_WIDTH-1:0] pipe_ready;
	logic [DISPATCH_WIDTH-1:0] pipe_valid;

	// Pipe to arbiter
	logic [DISPATCH_WIDTH-1:0] pipe_req;
	logic [DISPATCH_WIDTH-1:0] pipe_grant;
	wb_t [DISPATCH_WIDTH-1:0] pipe_wb;

	dispatch_queue i_queue (
		.clk        (clk),
		.rst_n      (rst_n),
		.wr_valid_i (wr_valid_i),
		.wr_uop_i   (wr_uop_i),
		.wr_ready_o (wr_ready_o),
		.rd_valid_o (rd_valid),
		.rd_uop_o   (rd_uop),
		.rd_ready_i (pipe_ready),
		.wb_valid_i (wb_valid_o),
		.wb_i       (wb_o)
	);

	// Younger lane reaches its pipe only when every older lane is taken
	always_comb begin
		logic older_ok;
		older_ok = 1'b1;
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			pipe_valid[i] = rd_valid[i] & older_ok;
			older_ok = older_ok & pipe_ready[i];
		end
	end

	for (genvar i = 0; i < DISPATCH_WIDTH; i++) begin : g_pipe
		alu_pipe i_alu (
			.clk        (clk),
			.rst_n      (rst_n),
			.in_valid_i (pipe_valid[i]),
			.in_uop_i   (rd_uop[i]),
			.in_ready_o (pipe_ready[i]),
			.req_o      (pipe_req[i]),
			.wb_o       (pipe_wb[i]),
			.grant_i    (pipe_grant[i])
		);
	end

	wb_arbiter i_arb (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (pipe_req),
		.wb_in_i    (pipe_wb),
		.grant_o    (pipe_grant),
		.wb_valid_o (wb_valid_o),
		.wb_o       (wb_o)
	);

endmodule : backend_top

/* source/be_pkg.sv */
// ====================
// Shared sizes and types for the back-end slice
// QUEUE_DEPTH must stay a power of two for pointer wrap
// ====================

package be_pkg;

	// ====================
	// Sizes
	// ====================

	// Micro-ops written per cycle
	localparam int DECODE_WIDTH = 2;
	// Dispatch lanes, lane i feeds ALU pipe i
	localparam int DISPATCH_WIDTH = 2;
	localparam int QUEUE_DEPTH = 8;
	localparam int PTAG_W = 5;
	localparam int DATA_W = 16;

	// Queue pointer and counter widths
	localparam int QPTR_W = $clog2(QUEUE_DEPTH);
	localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

	// ====================
	// Types
	// ====================

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0,
		ALU_SUB = 2'd1,
		ALU_XOR = 2'd2,
		ALU_AND = 2'd3
	} alu_op_e;

	// Decoded micro-op, operands travel with it
	typedef struct packed {
		logic [PTAG_W-1:0] pdest;
		logic [PTAG_W-1:0] src0;
		logic src0_ready;
		logic [PTAG_W-1:0] src1;
		logic src1_ready;
		alu_op_e op;
		logic [DATA_W-1:0] opa;
		logic [DATA_W-1:0] opb;
	} uop_t;

	// Result broadcast, also the wakeup
	typedef struct packed {
		logic [PTAG_W-1:0] tag;
		logic [DATA_W-1:0] result;
	} wb_t;

endpackage : be_pkg

/* source/dispatch_queue.sv */
// ====================
// In-order dispatch queue, two-wide write and two-lane read
// Write accepted only while count <= QUEUE_DEPTH - DECODE_WIDTH
// Lane 1 taken only together with lane 0
// ====================
`timescale 1ns/1ns

module dispatch_queue (
	input  logic clk,
	input  logic rst_n,
	input  logic [be_pkg::DECODE_WIDTH-1:0] wr_valid_i,
	input  be_pkg::uop_t [be_pkg::DECODE_WIDTH-1:0] wr_uop_i,
	output logic wr_ready_o,
	output logic [be_pkg::DISPATCH_WIDTH-1:0] rd_valid_o,
	output be_pkg::uop_t [be_pkg::DISPATCH_WIDTH-1:0] rd_uop_o,
	input  logic [be_pkg::DISPATCH_WIDTH-1:0] rd_ready_i,
	input  logic wb_valid_i,
	input  be_pkg::wb_t wb_i
);

	import be_pkg::*;

	// Entry storage, validity comes from head and count
	uop_t mem_q [QUEUE_DEPTH];
	uop_t mem_n [QUEUE_DEPTH];

	logic [QPTR_W-1:0] head_q, tail_q;
	logic [QCNT_W-1:0] cnt_q, cnt_n;

	logic [DECODE_WIDTH-1:0] wr_fire;
	logic [DISPATCH_WIDTH-1:0] rd_take;
	logic [QCNT_W-1:0] wr_cnt, rd_cnt;
	logic [QPTR_W-1:0] rd_idx [DISPATCH_WIDTH];

	// Set ready bits whose source tag matches the broadcast
	function automatic uop_t apply_wakeup(input uop_t u, input logic hit_v, input wb_t wb);
		uop_t r;
		r = u;
		if (hit_v && (u.src0 == wb.tag)) begin
			r.src0_ready = 1'b1;
		end
		if (hit_v && (u.src1 == wb.tag)) begin
			r.src1_ready = 1'b1;
		end
		return r;
	endfunction

	// ====================
	// Read side
	// ====================

	// Room for a full decode group, independent of the valids
	assign wr_ready_o = (cnt_q <= QCNT_W'(QUEUE_DEPTH - DECODE_WIDTH));
	assign wr_fire = wr_valid_i & {DECODE_WIDTH{wr_ready_o}};

	always_comb begin
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			rd_idx[i] = head_q + QPTR_W'(i);
			rd_uop_o[i] = mem_q[rd_idx[i]];
		end
		// Lane 0 needs the head present and both sources ready
		rd_valid_o[0] = (cnt_q > 0) && mem_q[rd_idx[0]].src0_ready
			&& mem_q[rd_idx[0]].src1_ready;
		// Younger lanes only behind a dispatchable older lane
		for (int i = 1; i < DISPATCH_WIDTH; i++) begin
			rd_valid_o[i] = rd_valid_o[i-1] && (cnt_q > QCNT_W'(i))
				&& mem_q[rd_idx[i]].src0_ready && mem_q[rd_idx[i]].src1_ready;
		end
	end

	// Taken lanes form a prefix, keeps program order
	always_comb begin
		rd_take[0] = rd_valid_o[0] & rd_ready_i[0];
		for (int i = 1; i < DISPATCH_WIDTH; i++) begin
			rd_take[i] = rd_take[i-1] & rd_valid_o[i] & rd_ready_i[i];
		end
	end

	// ====================
	// Next state
	// ====================

	always_comb begin
		logic [QPTR_W-1:0] wr_off;
		wr_off = '0;
		wr_cnt = '0;
		rd_cnt = '0;
		// Wakeup across every stored entry
		for (int k = 0; k < QUEUE_DEPTH; k++) begin
			mem_n[k] = apply_wakeup(mem_q[k], wb_valid_i, wb_i);
		end
		// Incoming lanes packed into consecutive slots, woken on entry too
		for (int i = 0; i < DECODE_WIDTH; i++) begin
			if (wr_fire[i]) begin
				mem_n[tail_q + wr_off] = apply_wakeup(wr_uop_i[i], wb_valid_i, wb_i);
				wr_off = wr_off + 1'b1;
				wr_cnt = wr_cnt + 1'b1;
			end
		end
		for (int i = 0; i < DISPATCH_WIDTH; i++) begin
			if (rd_take[i]) begin
				rd_cnt = rd_cnt + 1'b1;
			end
		end
		cnt_n = cnt_q + wr_cnt - rd_cnt;
	end

	// Payload only
	always_ff @(posedge clk) begin
		mem_q <= mem_n;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			head_q <= '0;
			tail_q <= '0;
			cnt_q <= '0;
		end else begin
			head_q <= head_q + rd_cnt[QPTR_W-1:0];
			tail_q <= tail_q + wr_cnt[QPTR_W-1:0];
			cnt_q <= cnt_n;
		end
	end

	// ====================
	// Checks
	// ====================

	// Occupancy bound across write and dispatch traffic
	a_cnt_bound: assert property (@(posedge clk) disable iff (!rst_n)
		cnt_q <= QCNT_W'(QUEUE_DEPTH))
		else $error("dispatch queue count above depth");

	a_lane_order: assert property (@(posedge clk) disable iff (!rst_n)
		rd_valid_o[1] |-> rd_valid_o[0])
		else $error("dispatch lane 1 valid without lane 0");

endmodule : dispatch_queue

/* source/wb_arbiter.sv */
// ====================
// Round-robin arbiter for two requesters on one writeback bus
// Loser of the last grant goes first, bus output is combinational
// ====================
`timescale 1ns/1ns

module wb_arbiter (
	input  logic clk,
	input  logic rst_n,
	input  logic [1:0] req_i,
	input  be_pkg::wb_t [1:0] wb_in_i,
	output logic [1:0] grant_o,
	output logic wb_valid_o,
	output be_pkg::wb_t wb_o
);

	import be_pkg::*;

	// Index of the requester with priority
	logic prio_q;

	always_comb begin
		if (!prio_q) begin
			grant_o[0] = req_i[0];
			grant_o[1] = req_i[1] & ~req_i[0];
		end else begin
			grant_o[1] = req_i[1];
			grant_o[0] = req_i[0] & ~req_i[1];
		end
	end

	// Bus mux
	assign wb_valid_o = |req_i;
	assign wb_o = grant_o[1] ? wb_in_i[1] : wb_in_i[0];

	// Priority flips to the side that lost, held when idle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			prio_q <= 1'b0;
		end else if (|grant_o) begin
			prio_q <= grant_o[0];
		end
	end

	// ====================
	// Checks
	// ====================

	a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant_o))
		else $error("writeback grant not one-hot");

	// Pipes hold their request, so a loser wins on the next cycle
	a_fair0: assert property (@(posedge clk) disable iff (!rst_n)
		req_i[0] && !grant_o[0] |=> grant_o[0])
		else $error("requester 0 starved");

	a_fair1: assert property (@(posedge clk) disable iff (!rst_n)
		req_i[1] && !grant_o[1] |=> grant_o[1])
		else $error("requester 1 starved");

endmodule : wb_arbiter
